// File: fetch_params.svh
/*
 * Fetch front end parameters.
 * Lane counts, BTB geometry and PC address layout.
 */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Lane counts.
`define FETCH_WIDTH 2
`define INT_ISSUE_WIDTH 2

// BTB geometry.
`define BTB_ENTRY_NUM 64
`define BTB_QUEUE_SIZE 4
`define BTB_QUEUE_PTR_WIDTH $clog2(`BTB_QUEUE_SIZE)

// Address layout. The index sits just above the instruction byte offset.
`define INSN_BYTE_WIDTH 4
`define PC_WIDTH 32
`define RESET_PC 32'h0000_1000
`define BTB_INDEX_LSB $clog2(`INSN_BYTE_WIDTH)
`define BTB_INDEX_WIDTH $clog2(`BTB_ENTRY_NUM)
`define BTB_TAG_WIDTH (`PC_WIDTH - `BTB_INDEX_WIDTH - `BTB_INDEX_LSB)

`endif

// File: fetchPkg.sv
/*
 * Fetch front end types.
 * PC, BTB entry and index types, branch results and BTB read ports.
 */
`include "fetch_params.svh"

package fetchPkg;

    typedef logic [`PC_WIDTH-1:0] PcPath;
    typedef logic [`BTB_INDEX_WIDTH-1:0] BtbIndexPath;
    typedef logic [`BTB_TAG_WIDTH-1:0] BtbTagPath;

    // One stored branch, target kept as a full address.
    typedef struct packed {
        logic valid;
        logic isCondBr;
        BtbTagPath tag;
        PcPath target;
    } BtbEntry;

    // Unit taken by the RAM write port and held in the write queue.
    typedef struct packed {
        BtbIndexPath index;
        BtbEntry entry;
    } BtbWrite;

    typedef struct packed {
        logic valid;
        logic taken;
        logic isCondBr;
        PcPath brAddr;
        PcPath nextAddr;
    } BranchResult;

    typedef struct packed {
        logic hit;
        logic isCondBr;
        PcPath target;
    } BtbRead;

    typedef enum logic {btbInit, btbRun} BtbState;

    typedef enum logic [1:0] {pcHold, pcRedirect, pcPredicted, pcSequential} PcSelect;

    function automatic BtbIndexPath toBtbIndex(PcPath pc);
        return pc[`BTB_INDEX_LSB +: `BTB_INDEX_WIDTH];
    endfunction

    function automatic BtbTagPath toBtbTag(PcPath pc);
        return pc[`PC_WIDTH-1 -: `BTB_TAG_WIDTH];
    endfunction

endpackage

// File: btbRam.sv
/*
 * BTB entry storage.
 * One bank per fetch lane, registered read, single write port.
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module btbRam import fetchPkg::*; (
    input  logic        clk,
    input  BtbIndexPath readIndex [`FETCH_WIDTH],
    output BtbEntry     readEntry [`FETCH_WIDTH],
    input  logic        writeEnable,
    input  BtbWrite     writeData
);

    localparam int BankNum = `FETCH_WIDTH;
    localparam int BankBits = $clog2(BankNum);
    localparam int BankDepth = `BTB_ENTRY_NUM / BankNum;

    typedef logic [BankBits-1:0] BankPath;
    typedef logic [`BTB_INDEX_WIDTH-BankBits-1:0] RowPath;

    BtbEntry bankMem [BankNum][BankDepth];
    RowPath  bankRow [BankNum];
    BtbEntry bankData [BankNum];
    BankPath laneBankReg [`FETCH_WIDTH];

    BankPath writeBank;
    RowPath  writeRow;

    assign writeBank = writeData.index[BankBits-1:0];
    assign writeRow = writeData.index[`BTB_INDEX_WIDTH-1:BankBits];

    // Route each lane's row address to the bank its low index bits select.
    always_comb begin
        for (int b = 0; b < BankNum; b++) begin
            bankRow[b] = '0;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (readIndex[i][BankBits-1:0] == BankPath'(b)) begin
                    bankRow[b] = readIndex[i][`BTB_INDEX_WIDTH-1:BankBits];
                end
            end
        end
    end

    for (genvar b = 0; b < BankNum; b++) begin : gBank
        // Old entry is returned on a read of the row being written.
        always_ff @(posedge clk) begin
            bankData[b] <= bankMem[b][bankRow[b]];
            if (writeEnable && writeBank == BankPath'(b)) begin
                bankMem[b][writeRow] <= writeData.entry;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            laneBankReg[i] <= readIndex[i][BankBits-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            readEntry[i] = bankData[laneBankReg[i]];
        end
    end

    // Lanes of one fetch group must land in distinct banks.
    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : gBankCheckI
        for (genvar j = i + 1; j < `FETCH_WIDTH; j++) begin : gBankCheckJ
            assert property (@(posedge clk)
                !$isunknown(readIndex[i]) && !$isunknown(readIndex[j]) |->
                readIndex[i][BankBits-1:0] != readIndex[j][BankBits-1:0])
            else $error("btbRam: lanes %0d and %0d read the same bank", i, j);
        end
    end

endmodule

// File: btbWriteQueue.sv
/*
 * BTB write queue.
 * Circular FIFO for branch-target writes that lost the RAM write port.
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module btbWriteQueue import fetchPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  BtbWrite pushData,
    input  logic    pop,
    output BtbWrite headData,
    output logic    empty,
    output logic    full
);

    typedef logic [`BTB_QUEUE_PTR_WIDTH-1:0] PtrPath;
    typedef logic [`BTB_QUEUE_PTR_WIDTH:0] CountPath;

    BtbWrite  queueMem [`BTB_QUEUE_SIZE];
    PtrPath   headPtr;
    PtrPath   tailPtr;
    CountPath count;

    logic doPush;
    logic doPop;

    // A push into a full queue is dropped.
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (doPop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            queueMem[tailPtr] <= pushData;
        end
    end

    assign headData = queueMem[headPtr];
    assign empty = (count == '0);
    assign full = (count == CountPath'(`BTB_QUEUE_SIZE));

    assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("btbWriteQueue: push while full, write dropped");

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else $error("btbWriteQueue: pop while empty");

endmodule

// File: btb.sv
/*
 * Branch target buffer.
 * Per-lane lookup with registered tag compare, write port arbitration
 * between direct and queued writes, and the post-reset clearing sweep.
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module btb import fetchPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  PcPath       predNextPc,
    input  BranchResult brResult [`INT_ISSUE_WIDTH],
    output BtbRead      btbRead [`FETCH_WIDTH],
    output logic        initBusy
);

    BtbState     state;
    BtbIndexPath initIndex;

    PcPath       laneAddr [`FETCH_WIDTH];
    PcPath       laneAddrReg [`FETCH_WIDTH];
    BtbIndexPath readIndex [`FETCH_WIDTH];
    BtbEntry     readEntry [`FETCH_WIDTH];

    logic    writeEnable;
    BtbWrite writeData;

    logic    firstTaken;
    logic    secondTaken;
    BtbWrite firstWrite;
    BtbWrite secondWrite;

    logic    initWrite;
    logic    directWrite;
    logic    pushQueue;
    logic    popQueue;
    BtbWrite headData;
    logic    queueEmpty;
    logic    queueFull;

    function automatic BtbWrite makeWrite(BranchResult r);
        BtbWrite w;
        w.index = toBtbIndex(r.brAddr);
        w.entry.valid = 1'b1;
        w.entry.isCondBr = r.isCondBr;
        w.entry.tag = toBtbTag(r.brAddr);
        w.entry.target = r.nextAddr;
        return w;
    endfunction

    btbRam ram (
        .clk         (clk),
        .readIndex   (readIndex),
        .readEntry   (readEntry),
        .writeEnable (writeEnable),
        .writeData   (writeData)
    );

    btbWriteQueue queue (
        .clk      (clk),
        .rst      (rst),
        .push     (pushQueue),
        .pushData (secondWrite),
        .pop      (popQueue),
        .headData (headData),
        .empty    (queueEmpty),
        .full     (queueFull)
    );

    // Init sweep clears one index per cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= btbInit;
            initIndex <= '0;
        end else if (state == btbInit) begin
            initIndex <= initIndex + 1'b1;
            if (initIndex == BtbIndexPath'(`BTB_ENTRY_NUM - 1)) begin
                state <= btbRun;
            end
        end
    end

    assign initBusy = (state == btbInit);

    // Lane addresses of the group being looked up.
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            laneAddr[i] = predNextPc + PcPath'(i * `INSN_BYTE_WIDTH);
            readIndex[i] = toBtbIndex(laneAddr[i]);
        end
    end

    always_ff @(posedge clk) begin
        laneAddrReg <= laneAddr;
    end

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            btbRead[i].hit = readEntry[i].valid && (state == btbRun) &&
                             (readEntry[i].tag == toBtbTag(laneAddrReg[i]));
            btbRead[i].isCondBr = readEntry[i].isCondBr;
            btbRead[i].target = readEntry[i].target;
        end
    end

    // Lowest taken lane goes direct, the next one is parked.
    always_comb begin
        firstTaken = 1'b0;
        secondTaken = 1'b0;
        firstWrite = '0;
        secondWrite = '0;
        for (int k = 0; k < `INT_ISSUE_WIDTH; k++) begin
            if (brResult[k].valid && brResult[k].taken) begin
                if (!firstTaken) begin
                    firstTaken = 1'b1;
                    firstWrite = makeWrite(brResult[k]);
                end else if (!secondTaken) begin
                    secondTaken = 1'b1;
                    secondWrite = makeWrite(brResult[k]);
                end
            end
        end
    end

    assign initWrite = (state == btbInit);
    assign directWrite = (state == btbRun) && firstTaken;
    assign pushQueue = (state == btbRun) && secondTaken;
    assign popQueue = (state == btbRun) && !firstTaken && !queueEmpty;

    always_comb begin
        writeEnable = initWrite || directWrite || popQueue;
        if (initWrite) begin
            writeData.index = initIndex;
            writeData.entry = '0;
        end else if (directWrite) begin
            writeData = firstWrite;
        end else begin
            writeData = headData;
        end
    end

    // Only the first taken result goes direct, so the second must find room.
    assert property (@(posedge clk) disable iff (rst) pushQueue |-> !queueFull)
    else $error("btb: second taken result lost, write queue full");

endmodule

// File: nextPcStage.sv
/*
 * Next-PC stage.
 * Picks redirect, BTB target or fall-through and registers the fetch PC.
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module nextPcStage import fetchPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   redirectValid,
    input  PcPath  redirectPc,
    input  BtbRead btbRead [`FETCH_WIDTH],
    input  logic   initBusy,
    output PcPath  predNextPc,
    output PcPath  fetchPc
);

    PcSelect pcSel;
    PcPath   predTarget;

    always_comb begin
        pcSel = pcSequential;
        predTarget = '0;
        if (initBusy) begin
            pcSel = pcHold;
        end else if (redirectValid) begin
            pcSel = pcRedirect;
        end else begin
            // Walk down so the first hitting lane wins.
            for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
                if (btbRead[i].hit) begin
                    pcSel = pcPredicted;
                    predTarget = btbRead[i].target;
                end
            end
        end

        case (pcSel)
            pcHold: predNextPc = fetchPc;
            pcRedirect: predNextPc = redirectPc;
            pcPredicted: predNextPc = predTarget;
            default: predNextPc = fetchPc + PcPath'(`FETCH_WIDTH * `INSN_BYTE_WIDTH);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPc <= `RESET_PC;
        end else begin
            fetchPc <= predNextPc;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        fetchPc[`BTB_INDEX_LSB-1:0] == '0)
    else $error("nextPcStage: fetchPc %h not instruction aligned", fetchPc);

endmodule

// File: fetchFrontEnd.sv
/*
 * Fetch front end top.
 * Next-PC stage and branch target buffer.
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetchFrontEnd import fetchPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        redirectValid,
    input  PcPath       redirectPc,
    input  BranchResult brResult [`INT_ISSUE_WIDTH],
    output PcPath       fetchPc,
    output BtbRead      btbRead [`FETCH_WIDTH],
    output logic        initBusy
);

    PcPath predNextPc;

    nextPcStage npStage (
        .clk           (clk),
        .rst           (rst),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .btbRead       (btbRead),
        .initBusy      (initBusy),
        .predNextPc    (predNextPc),
        .fetchPc       (fetchPc)
    );

    btb btbUnit (
        .clk        (clk),
        .rst        (rst),
        .predNextPc (predNextPc),
        .brResult   (brResult),
        .btbRead    (btbRead),
        .initBusy   (initBusy)
    );

endmodule

// File: tbFetchFrontEnd.sv
/*
 * Fetch front end testbench.
 * Random branch training from an LFSR, redirect probes of the trained
 * groups, and a BTB reference model for the expected reads and next PC.
 */
`timescale 1ns/10ps
`include "fetch_params.svh"

module tbFetchFrontEnd import fetchPkg::*; ();

    localparam int IdxLsb = $clog2(`INSN_BYTE_WIDTH);
    localparam int IdxWidth = $clog2(`BTB_ENTRY_NUM);
    localparam int ResetCycles = 16;
    localparam int ColdCycles = 20;
    localparam int TrainNum = 40;
    localparam int InitCycles = ResetCycles + `BTB_ENTRY_NUM + 2;
    localparam int TrainCycles = 2 * (TrainNum + 2) + `BTB_QUEUE_SIZE + 2;
    localparam int ProbeCycles = 3 * (`INT_ISSUE_WIDTH * TrainNum + 1);
    localparam int TimeoutCycles = InitCycles + ColdCycles + TrainCycles + ProbeCycles + 50;

    logic        clk;
    logic        rst;
    logic        redirectValid;
    PcPath       redirectPc;
    BranchResult brResult [`INT_ISSUE_WIDTH];
    PcPath       fetchPc;
    BtbRead      btbRead [`FETCH_WIDTH];
    logic        initBusy;

    BranchResult pending [`INT_ISSUE_WIDTH];
    BtbEntry     model [`BTB_ENTRY_NUM];
    PcPath       probeList [$];
    logic [15:0] lfsr;
    int          cycleCount = 0;
    int          pcErrors = 0;
    int          readErrors = 0;
    int          bitErrors = 0;

    fetchFrontEnd uut (
        .clk           (clk),
        .rst           (rst),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .brResult      (brResult),
        .fetchPc       (fetchPc),
        .btbRead       (btbRead),
        .initBusy      (initBusy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles.", TimeoutCycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Taps 16, 14, 13, 11.
    function automatic logic stepLfsr();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], stepLfsr()};
        end
        return v;
    endfunction

    function automatic BtbIndexPath indexOf(PcPath a);
        return BtbIndexPath'(a >> IdxLsb);
    endfunction

    function automatic BtbTagPath tagOf(PcPath a);
        return BtbTagPath'(a >> (IdxLsb + IdxWidth));
    endfunction

    function automatic BranchResult makeResult(logic taken, logic cond, PcPath br, PcPath nxt);
        BranchResult r;
        r.valid = 1'b1;
        r.taken = taken;
        r.isCondBr = cond;
        r.brAddr = br;
        r.nextAddr = nxt;
        return r;
    endfunction

    // Only taken results allocate.
    function automatic void trainModel(BranchResult r);
        BtbIndexPath idx;
        idx = indexOf(r.brAddr);
        if (r.valid && r.taken) begin
            model[idx].valid = 1'b1;
            model[idx].isCondBr = r.isCondBr;
            model[idx].tag = tagOf(r.brAddr);
            model[idx].target = r.nextAddr;
        end
    endfunction

    function automatic BtbRead expectRead(PcPath a);
        BtbEntry e;
        BtbRead r;
        e = model[indexOf(a)];
        r.hit = e.valid && (e.tag == tagOf(a));
        r.isCondBr = e.isCondBr;
        r.target = e.target;
        return r;
    endfunction

    task automatic checkPc(string name, PcPath got, PcPath exp);
        if (got !== exp) begin
            pcErrors++;
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    // Target and isCondBr only matter on a hit.
    task automatic checkRead(int lane, BtbRead got, BtbRead exp);
        logic bad;
        bad = (got.hit !== exp.hit);
        if (exp.hit) begin
            bad = bad || (got !== exp);
        end
        if (bad) begin
            readErrors++;
            $display("MISMATCH time=%0t signal=btbRead[%0d] got=%h expected=%h",
                     $time, lane, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            bitErrors++;
            $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
        end
    endtask

    // Walk lanes from the top so the lowest hitting lane sets the next PC.
    task automatic checkGroup(PcPath g, output PcPath predicted);
        BtbRead exp;
        predicted = g + PcPath'(`FETCH_WIDTH * `INSN_BYTE_WIDTH);
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            exp = expectRead(g + PcPath'(i * `INSN_BYTE_WIDTH));
            checkRead(i, btbRead[i], exp);
            if (exp.hit) begin
                predicted = exp.target;
            end
        end
    endtask

    task automatic issuePending();
        @(posedge clk);
        for (int k = 0; k < `INT_ISSUE_WIDTH; k++) begin
            brResult[k] <= pending[k];
            trainModel(pending[k]);
        end
        @(posedge clk);
        for (int k = 0; k < `INT_ISSUE_WIDTH; k++) begin
            brResult[k] <= '0;
        end
    endtask

    task automatic probeGroup(PcPath g);
        PcPath predicted;
        PcPath unused;
        @(posedge clk);
        redirectValid <= 1'b1;
        redirectPc <= g;
        @(posedge clk);
        redirectValid <= 1'b0;
        @(negedge clk);
        checkPc("fetchPc", fetchPc, g);
        checkGroup(g, predicted);
        @(posedge clk);
        @(negedge clk);
        checkPc("fetchPc", fetchPc, predicted);
        checkGroup(predicted, unused);
    endtask

    initial begin
        PcPath      expPc;
        PcPath      nxt;
        PcPath      addr;
        PcPath      target;
        logic [1:0] mode;
        logic       taken;
        logic       cond;
        int         total;
        clk = 1'b0;
        rst = 1'b1;
        redirectValid = 1'b0;
        redirectPc = '0;
        lfsr = 16'd1729;
        for (int k = 0; k < `INT_ISSUE_WIDTH; k++) begin
            brResult[k] = '0;
            pending[k] = '0;
        end
        for (int e = 0; e < `BTB_ENTRY_NUM; e++) begin
            model[e] = '0;
        end

        // Reset, then the clearing sweep.
        for (int i = 0; i < ResetCycles - 1 + `BTB_ENTRY_NUM; i++) begin
            @(posedge clk);
            if (i == ResetCycles - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            checkBit("initBusy", initBusy, 1'b1);
            checkPc("fetchPc", fetchPc, `RESET_PC);
            checkGroup(`RESET_PC, nxt);
        end

        // Cold misses, sequential fetch.
        expPc = `RESET_PC;
        for (int i = 0; i < ColdCycles; i++) begin
            @(posedge clk);
            @(negedge clk);
            checkBit("initBusy", initBusy, 1'b0);
            checkPc("fetchPc", fetchPc, expPc);
            checkGroup(expPc, nxt);
            expPc = nxt;
        end

        // Random training, one or two taken lanes per issue cycle.
        for (int n = 0; n < TrainNum; n++) begin
            mode = 2'(randBits(2));
            for (int k = 0; k < `INT_ISSUE_WIDTH; k++) begin
                taken = (k == 0) ? (mode != 2'd1) : (mode != 2'd0);
                cond = 1'(randBits(1));
                addr = 32'h2000 + (randBits(7) << 2);
                target = 32'h3000 + (randBits(8) << 2);
                pending[k] = makeResult(taken, cond, addr, target);
                if (taken) begin
                    probeList.push_back(addr - (randBits(1) << 2));
                end else begin
                    probeList.push_back(addr);
                end
            end
            issuePending();
        end

        // Dual taken pair, then an overwrite of lane 0.
        pending[0] = makeResult(1'b1, 1'b1, 32'h2400, 32'h3800);
        pending[1] = makeResult(1'b1, 1'b0, 32'h2404, 32'h3900);
        issuePending();
        pending[0] = makeResult(1'b1, 1'b0, 32'h2400, 32'h3A00);
        pending[1] = '0;
        issuePending();
        probeList.push_back(32'h2400);

        repeat (`BTB_QUEUE_SIZE + 2) @(posedge clk);

        foreach (probeList[p]) begin
            probeGroup(probeList[p]);
        end

        total = pcErrors + readErrors + bitErrors;
        $display("Errors: fetchPc %0d, btbRead %0d, initBusy %0d, total %0d",
                 pcErrors, readErrors, bitErrors, total);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+.
fetchPkg.sv
btbRam.sv
btbWriteQueue.sv
btb.sv
nextPcStage.sv
fetchFrontEnd.sv
tbFetchFrontEnd.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - .
    files:
      - fetchPkg.sv
      - btbRam.sv
      - btbWriteQueue.sv
      - btb.sv
      - nextPcStage.sv
      - fetchFrontEnd.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbFetchFrontEnd.sv
